/* design/fe_cfg.svh */
// ----------------------------
// frontend configuration macros
// address width, predictor size and
// fetch queue depth
// ----------------------------
`ifndef FE_CFG_SVH
`define FE_CFG_SVH

// virtual address width, one fetch is one 32-bit word
`define FE_VLEN 32

// branch history table entries
// indexed by pc[5:2] for 16 entries
`define FE_BHT_ENTRIES 16

// entries buffered between fetch and decode
`define FE_QUEUE_DEPTH 4

`endif

/* design/fe_pkg.sv */
// ----------------------------
// frontend types
// major opcode classes seen by the scanner
// predicted control flow of a fetch entry
// ----------------------------
package fe_pkg;

  // major opcodes the scanner tells apart
  typedef enum logic [6:0] {
    BRANCH = 7'b1100011,
    JALR   = 7'b1100111,
    JAL    = 7'b1101111,
    // any opcode without a control transfer
    OTHER  = 7'b0010011
  } opcode_e;

  // control flow attached to an entry on its way to decode
  typedef enum logic [1:0] {
    // sequential, target is pc + 4
    NO_CF     = 2'd0,
    // conditional branch predicted taken
    BRANCH_CF = 2'd1,
    // jal, always taken
    JUMP_CF   = 2'd2
  } cf_e;

endpackage

/* design/instr_scan.sv */
// ----------------------------
// instruction scanner
// flags branches and jal in one 32-bit word
// and builds the sign-extended offset
// ----------------------------
`timescale 1ns/1ns
`include "fe_cfg.svh"

module instr_scan (
  input  logic [31:0]         instr_i,
  output logic                is_branch_o,
  output logic                is_jal_o,
  output logic [`FE_VLEN-1:0] imm_o
);

  fe_pkg::opcode_e     opcode;
  logic [`FE_VLEN-1:0] b_imm;
  logic [`FE_VLEN-1:0] j_imm;

  // classify the major opcode, everything unknown is OTHER
  always_comb begin
    case (instr_i[6:0])
      fe_pkg::BRANCH: opcode = fe_pkg::BRANCH;
      fe_pkg::JAL:    opcode = fe_pkg::JAL;
      fe_pkg::JALR:   opcode = fe_pkg::JALR;
      default:        opcode = fe_pkg::OTHER;
    endcase
  end

  // jalr needs a register operand, so it is left to the backend
  assign is_branch_o = (opcode == fe_pkg::BRANCH);
  assign is_jal_o    = (opcode == fe_pkg::JAL);

  // b-type offset imm[12|10:5|4:1|11]
  assign b_imm = {{(`FE_VLEN-12){instr_i[31]}}, instr_i[7],
                  instr_i[30:25], instr_i[11:8], 1'b0};

  // j-type offset imm[20|10:1|11|19:12]
  assign j_imm = {{(`FE_VLEN-20){instr_i[31]}}, instr_i[19:12],
                  instr_i[20], instr_i[30:21], 1'b0};

  // sign bit of the branch offset doubles as the static hint
  assign imm_o = is_jal_o ? j_imm : b_imm;

endmodule

/* design/bht.sv */
// ----------------------------
// branch history table
// 2-bit saturating counters with valid bits
// combinational read, one update per cycle
// ----------------------------
`timescale 1ns/1ns
`include "fe_cfg.svh"

module bht (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                flush_i,
  input  logic [`FE_VLEN-1:0] pc_i,
  input  logic                update_valid_i,
  input  logic [`FE_VLEN-1:0] update_pc_i,
  input  logic                update_taken_i,
  output logic                valid_o,
  output logic                taken_o
);

  localparam int unsigned ENTRIES = `FE_BHT_ENTRIES;
  localparam int unsigned IDX_W   = $clog2(ENTRIES);

  logic [ENTRIES-1:0] valid_q;
  logic [1:0]         cnt_q [ENTRIES];
  logic [IDX_W-1:0]   rd_idx;
  logic [IDX_W-1:0]   upd_idx;

  // word aligned index, the two lsbs are always zero
  assign rd_idx  = pc_i[IDX_W+1:2];
  assign upd_idx = update_pc_i[IDX_W+1:2];

  // msb of the counter is the direction
  assign valid_o = valid_q[rd_idx];
  assign taken_o = cnt_q[rd_idx][1];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
    end else if (flush_i) begin
      valid_q <= '0;
    end else if (update_valid_i) begin
      valid_q[upd_idx] <= 1'b1;
    end
  end

  // first update starts weakly taken or weakly not taken
  // later ones saturate between 0 and 3
  always_ff @(posedge clk_i) begin
    if (update_valid_i) begin
      if (!valid_q[upd_idx]) begin
        cnt_q[upd_idx] <= update_taken_i ? 2'd2 : 2'd1;
      end else if (update_taken_i && cnt_q[upd_idx] != 2'd3) begin
        cnt_q[upd_idx] <= cnt_q[upd_idx] + 2'd1;
      end else if (!update_taken_i && cnt_q[upd_idx] != 2'd0) begin
        cnt_q[upd_idx] <= cnt_q[upd_idx] - 2'd1;
      end
    end
  end

endmodule

/* design/fetch_predict.sv */
// ----------------------------
// fetch response register and prediction
// scans the registered word, reads the bht,
// picks control flow and target
// ----------------------------
`timescale 1ns/1ns
`include "fe_cfg.svh"

module fetch_predict (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                redirect_i,
  input  logic                imem_valid_i,
  input  logic [`FE_VLEN-1:0] imem_raddr_i,
  input  logic [31:0]         imem_rdata_i,
  input  logic                resolve_valid_i,
  input  logic                resolve_is_branch_i,
  input  logic [`FE_VLEN-1:0] resolve_pc_i,
  input  logic                resolve_taken_i,
  output logic                entry_valid_o,
  output logic [`FE_VLEN-1:0] entry_pc_o,
  output logic [31:0]         entry_instr_o,
  output fe_pkg::cf_e         entry_cf_o,
  output logic [`FE_VLEN-1:0] entry_target_o,
  output logic                bp_valid_o,
  output logic [`FE_VLEN-1:0] predict_addr_o
);

  logic                valid_q;
  logic [`FE_VLEN-1:0] pc_q;
  logic [31:0]         instr_q;
  logic                is_branch;
  logic                is_jal;
  logic [`FE_VLEN-1:0] imm;
  logic                bht_valid;
  logic                bht_taken;
  logic                branch_taken;

  // ------------------------------
  // response register
  // ------------------------------
  // a taken prediction drops the sequential word arriving now
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= imem_valid_i & ~redirect_i & ~bp_valid_o;
    end
  end

  always_ff @(posedge clk_i) begin
    if (imem_valid_i) begin
      pc_q    <= imem_raddr_i;
      instr_q <= imem_rdata_i;
    end
  end

  instr_scan u_instr_scan (
    .instr_i     (instr_q),
    .is_branch_o (is_branch),
    .is_jal_o    (is_jal),
    .imm_o       (imm)
  );

  // history survives pipeline redirects, there is no predictor flush
  bht u_bht (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .flush_i        (1'b0),
    .pc_i           (pc_q),
    .update_valid_i (resolve_valid_i & resolve_is_branch_i),
    .update_pc_i    (resolve_pc_i),
    .update_taken_i (resolve_taken_i),
    .valid_o        (bht_valid),
    .taken_o        (bht_taken)
  );

  // ------------------------------
  // prediction
  // ------------------------------
  // dynamic if the bht knows the branch, else backward taken
  assign branch_taken = bht_valid ? bht_taken : imm[`FE_VLEN-1];

  always_comb begin
    if (is_jal) begin
      entry_cf_o = fe_pkg::JUMP_CF;
    end else if (is_branch && branch_taken) begin
      entry_cf_o = fe_pkg::BRANCH_CF;
    end else begin
      entry_cf_o = fe_pkg::NO_CF;
    end
  end

  assign entry_target_o = (entry_cf_o == fe_pkg::NO_CF) ? pc_q + `FE_VLEN'(4) : pc_q + imm;

  // taken prediction steers the next request
  assign bp_valid_o     = valid_q & (entry_cf_o != fe_pkg::NO_CF);
  assign predict_addr_o = entry_target_o;

  assign entry_valid_o = valid_q;
  assign entry_pc_o    = pc_q;
  assign entry_instr_o = instr_q;

endmodule

/* design/pc_gen.sv */
// ----------------------------
// next pc generation
// boot load, redirect priority and
// instruction memory request
// ----------------------------
`timescale 1ns/1ns
`include "fe_cfg.svh"

module pc_gen (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic [`FE_VLEN-1:0] boot_addr_i,
  input  logic                flush_i,
  input  logic                eret_i,
  input  logic [`FE_VLEN-1:0] epc_i,
  input  logic                ex_valid_i,
  input  logic [`FE_VLEN-1:0] trap_vector_i,
  input  logic                set_pc_commit_i,
  input  logic [`FE_VLEN-1:0] pc_commit_i,
  input  logic                halt_i,
  input  logic                resolve_valid_i,
  input  logic                resolve_mispredict_i,
  input  logic [`FE_VLEN-1:0] resolve_target_i,
  input  logic                bp_valid_i,
  input  logic [`FE_VLEN-1:0] predict_addr_i,
  input  logic                queue_ready_i,
  input  logic                replay_i,
  input  logic [`FE_VLEN-1:0] replay_addr_i,
  input  logic                imem_ready_i,
  output logic                imem_req_o,
  output logic [`FE_VLEN-1:0] imem_addr_o,
  output logic                imem_kill_o,
  output logic                redirect_o
);

  logic                boot_q;
  logic [`FE_VLEN-1:0] npc_q;
  logic [`FE_VLEN-1:0] npc_d;
  logic [`FE_VLEN-1:0] fetch_addr;
  logic                mispredict;
  logic                accept;

  assign mispredict = resolve_valid_i & resolve_mispredict_i;

  // anything from the backend that restarts the stream
  assign redirect_o  = flush_i | eret_i | ex_valid_i | set_pc_commit_i | mispredict;
  assign imem_kill_o = redirect_o | replay_i;

  // no request while the boot address is loaded
  assign imem_req_o = queue_ready_i & ~boot_q;
  assign accept     = imem_req_o & imem_ready_i & ~imem_kill_o;

  // boot address first, then the pc, a taken prediction overrides both
  always_comb begin
    fetch_addr = boot_q ? boot_addr_i : npc_q;
    if (bp_valid_i) begin
      fetch_addr = predict_addr_i;
    end
  end

  assign imem_addr_o = fetch_addr;

  // ------------------------------
  // next pc, lowest priority first
  // ------------------------------
  always_comb begin
    // hold
    npc_d = fetch_addr;
    if (accept) begin
      npc_d = {fetch_addr[`FE_VLEN-1:2], 2'b00} + `FE_VLEN'(4);
    end
    // refetch the entry the full queue could not take
    if (replay_i) begin
      npc_d = replay_addr_i;
    end
    if (mispredict) begin
      npc_d = resolve_target_i;
    end
    if (eret_i) begin
      npc_d = epc_i;
    end
    if (ex_valid_i) begin
      npc_d = trap_vector_i;
    end
    // a halted commit resumes at its own pc
    if (set_pc_commit_i) begin
      npc_d = pc_commit_i + (halt_i ? `FE_VLEN'(0) : `FE_VLEN'(4));
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      boot_q <= 1'b1;
      npc_q  <= '0;
    end else begin
      boot_q <= 1'b0;
      npc_q  <= npc_d;
    end
  end

endmodule

/* design/fetch_queue.sv */
// ----------------------------
// fetch queue toward decode
// circular buffer with push and pop in one cycle
// replay request when an entry meets a full queue
// ----------------------------
`timescale 1ns/1ns
`include "fe_cfg.svh"

module fetch_queue (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                flush_i,
  input  logic                entry_valid_i,
  input  logic [`FE_VLEN-1:0] entry_pc_i,
  input  logic [31:0]         entry_instr_i,
  input  fe_pkg::cf_e         entry_cf_i,
  input  logic [`FE_VLEN-1:0] entry_target_i,
  output logic                ready_o,
  output logic                replay_o,
  output logic [`FE_VLEN-1:0] replay_addr_o,
  output logic                fetch_valid_o,
  input  logic                fetch_ready_i,
  output logic [`FE_VLEN-1:0] fetch_pc_o,
  output logic [31:0]         fetch_instr_o,
  output fe_pkg::cf_e         fetch_cf_o,
  output logic [`FE_VLEN-1:0] fetch_target_o
);

  localparam int unsigned DEPTH = `FE_QUEUE_DEPTH;
  localparam int unsigned PTR_W = $clog2(DEPTH);

  logic [`FE_VLEN-1:0] pc_mem     [DEPTH];
  logic [31:0]         instr_mem  [DEPTH];
  fe_pkg::cf_e         cf_mem     [DEPTH];
  logic [`FE_VLEN-1:0] target_mem [DEPTH];
  logic [PTR_W-1:0]    rd_ptr_q;
  logic [PTR_W-1:0]    wr_ptr_q;
  logic [PTR_W:0]      count_q;
  logic                full;
  logic                push;
  logic                pop;

  // wrap at the last entry
  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign full    = (count_q == (PTR_W+1)'(DEPTH));
  assign ready_o = ~full;

  // a full queue sends the entry back to be fetched again
  assign replay_o      = entry_valid_i & full;
  assign replay_addr_o = entry_pc_i;

  assign push = entry_valid_i & ~full;
  assign pop  = fetch_valid_o & fetch_ready_i;

  // head of the queue drives decode straight from storage
  assign fetch_valid_o  = (count_q != '0);
  assign fetch_pc_o     = pc_mem[rd_ptr_q];
  assign fetch_instr_o  = instr_mem[rd_ptr_q];
  assign fetch_cf_o     = cf_mem[rd_ptr_q];
  assign fetch_target_o = target_mem[rd_ptr_q];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else if (flush_i) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
      count_q <= count_q + (PTR_W+1)'(push) - (PTR_W+1)'(pop);
    end
  end

  // never writes the head, push only happens when not full
  always_ff @(posedge clk_i) begin
    if (push) begin
      pc_mem[wr_ptr_q]     <= entry_pc_i;
      instr_mem[wr_ptr_q]  <= entry_instr_i;
      cf_mem[wr_ptr_q]     <= entry_cf_i;
      target_mem[wr_ptr_q] <= entry_target_i;
    end
  end

endmodule

/* design/frontend_top.sv */
// ----------------------------
// instruction fetch frontend
// pc generation, fetch register with
// prediction and the fetch queue
// ----------------------------
`timescale 1ns/1ns
`include "fe_cfg.svh"

module frontend_top (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic [`FE_VLEN-1:0] boot_addr_i,
  // redirects from the backend
  input  logic                flush_i,
  input  logic                eret_i,
  input  logic [`FE_VLEN-1:0] epc_i,
  input  logic                ex_valid_i,
  input  logic [`FE_VLEN-1:0] trap_vector_i,
  input  logic                set_pc_commit_i,
  input  logic [`FE_VLEN-1:0] pc_commit_i,
  input  logic                halt_i,
  // branch resolution, one cycle strobes
  input  logic                resolve_valid_i,
  input  logic [`FE_VLEN-1:0] resolve_pc_i,
  input  logic                resolve_is_branch_i,
  input  logic                resolve_taken_i,
  input  logic                resolve_mispredict_i,
  input  logic [`FE_VLEN-1:0] resolve_target_i,
  // instruction memory
  output logic                imem_req_o,
  output logic [`FE_VLEN-1:0] imem_addr_o,
  output logic                imem_kill_o,
  input  logic                imem_ready_i,
  input  logic                imem_valid_i,
  input  logic [`FE_VLEN-1:0] imem_raddr_i,
  input  logic [31:0]         imem_rdata_i,
  // decode
  output logic                fetch_valid_o,
  input  logic                fetch_ready_i,
  output logic [`FE_VLEN-1:0] fetch_pc_o,
  output logic [31:0]         fetch_instr_o,
  output fe_pkg::cf_e         fetch_cf_o,
  output logic [`FE_VLEN-1:0] fetch_target_o
);

  logic                redirect;
  logic                bp_valid;
  logic [`FE_VLEN-1:0] predict_addr;
  logic                queue_ready;
  logic                replay;
  logic [`FE_VLEN-1:0] replay_addr;
  logic                entry_valid;
  logic [`FE_VLEN-1:0] entry_pc;
  logic [31:0]         entry_instr;
  fe_pkg::cf_e         entry_cf;
  logic [`FE_VLEN-1:0] entry_target;

  pc_gen u_pc_gen (
    .clk_i                (clk_i),
    .rst_ni               (rst_ni),
    .boot_addr_i          (boot_addr_i),
    .flush_i              (flush_i),
    .eret_i               (eret_i),
    .epc_i                (epc_i),
    .ex_valid_i           (ex_valid_i),
    .trap_vector_i        (trap_vector_i),
    .set_pc_commit_i      (set_pc_commit_i),
    .pc_commit_i          (pc_commit_i),
    .halt_i               (halt_i),
    .resolve_valid_i      (resolve_valid_i),
    .resolve_mispredict_i (resolve_mispredict_i),
    .resolve_target_i     (resolve_target_i),
    .bp_valid_i           (bp_valid),
    .predict_addr_i       (predict_addr),
    .queue_ready_i        (queue_ready),
    .replay_i             (replay),
    .replay_addr_i        (replay_addr),
    .imem_ready_i         (imem_ready_i),
    .imem_req_o           (imem_req_o),
    .imem_addr_o          (imem_addr_o),
    .imem_kill_o          (imem_kill_o),
    .redirect_o           (redirect)
  );

  // kill covers redirect and replay, a replay also has to drop
  // the word in flight or it would overtake the refetched entry
  fetch_predict u_fetch_predict (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .redirect_i          (imem_kill_o),
    .imem_valid_i        (imem_valid_i),
    .imem_raddr_i        (imem_raddr_i),
    .imem_rdata_i        (imem_rdata_i),
    .resolve_valid_i     (resolve_valid_i),
    .resolve_is_branch_i (resolve_is_branch_i),
    .resolve_pc_i        (resolve_pc_i),
    .resolve_taken_i     (resolve_taken_i),
    .entry_valid_o       (entry_valid),
    .entry_pc_o          (entry_pc),
    .entry_instr_o       (entry_instr),
    .entry_cf_o          (entry_cf),
    .entry_target_o      (entry_target),
    .bp_valid_o          (bp_valid),
    .predict_addr_o      (predict_addr)
  );

  fetch_queue u_fetch_queue (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .flush_i        (redirect),
    .entry_valid_i  (entry_valid),
    .entry_pc_i     (entry_pc),
    .entry_instr_i  (entry_instr),
    .entry_cf_i     (entry_cf),
    .entry_target_i (entry_target),
    .ready_o        (queue_ready),
    .replay_o       (replay),
    .replay_addr_o  (replay_addr),
    .fetch_valid_o  (fetch_valid_o),
    .fetch_ready_i  (fetch_ready_i),
    .fetch_pc_o     (fetch_pc_o),
    .fetch_instr_o  (fetch_instr_o),
    .fetch_cf_o     (fetch_cf_o),
    .fetch_target_o (fetch_target_o)
  );

endmodule

/* tb/tb_frontend.sv */
// ----------------------------
// frontend testbench
// clock, reset, memory model with random stall
// random decode ready, reference pc stream
// concurrent checks, report and timeout
// ----------------------------
`timescale 1ns/1ns
`include "fe_cfg.svh"

module tb_frontend;

  localparam int unsigned LIMIT = 4000;
  localparam logic [31:0] BOOT = 32'h0000_1000;

  logic clk_i, rst_ni;
  logic [`FE_VLEN-1:0] boot_addr_i, epc_i, trap_vector_i, pc_commit_i;
  logic flush_i, eret_i, ex_valid_i, set_pc_commit_i, halt_i;
  logic resolve_valid_i, resolve_is_branch_i, resolve_taken_i, resolve_mispredict_i;
  logic [`FE_VLEN-1:0] resolve_pc_i, resolve_target_i;
  logic imem_req_o, imem_kill_o, imem_ready_i, imem_valid_i;
  logic [`FE_VLEN-1:0] imem_addr_o, imem_raddr_i;
  logic [31:0] imem_rdata_i;
  logic fetch_valid_o, fetch_ready_i;
  logic [`FE_VLEN-1:0] fetch_pc_o, fetch_target_o;
  logic [31:0] fetch_instr_o;
  fe_pkg::cf_e fetch_cf_o;

  // placed control flow words with kind 1 for jal and 2 for a branch
  logic [31:0] code [logic [31:0]];
  int          kind [logic [31:0]];
  logic [31:0] offs [logic [31:0]];
  // predictor model
  logic        bht_v [16];
  logic [1:0]  bht_c [16];

  int          seed = 32'hac48eb59;
  int          errors = 0;
  int          n_xfer = 0;
  int          cycles = 0;
  int          err_mark;
  logic [31:0] exp_pc;
  logic [31:0] exp_instr, exp_target;
  fe_pkg::cf_e exp_cf;
  logic        xfer, taken;
  logic        redirect, sets_pc;

  frontend_top u_dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  // filler words are OTHER with the address folded into the upper bits
  function automatic logic [31:0] word_at(input logic [31:0] a);
    if (code.exists(a)) return code[a];
    return {a[31:7] ^ a[26:2], 7'b0010011};
  endfunction

  task automatic place_jal(input logic [31:0] a, input logic [31:0] o);
    code[a] = {o[20], o[10:1], o[11], o[19:12], 5'd1, 7'b1101111};
    kind[a] = 1;
    offs[a] = o;
  endtask

  task automatic place_branch(input logic [31:0] a, input logic [31:0] o);
    code[a] = {o[12], o[10:5], 5'd2, 5'd1, 3'b000, o[4:1], o[11], 7'b1100011};
    kind[a] = 2;
    offs[a] = o;
  endtask

  // ------------------------------
  // memory model, one cycle latency
  // ------------------------------
  always @(posedge clk_i) begin
    imem_ready_i  <= ($random(seed) & 3) != 0;
    fetch_ready_i <= ($random(seed) & 1) != 0;
    imem_valid_i  <= rst_ni & imem_req_o & imem_ready_i & ~imem_kill_o;
    imem_raddr_i  <= imem_addr_o;
    imem_rdata_i  <= word_at(imem_addr_o);
  end

  // backend strobes that restart the stream
  // flush restarts without naming a new pc
  always_comb begin
    sets_pc  = set_pc_commit_i | ex_valid_i | eret_i |
               (resolve_valid_i & resolve_mispredict_i);
    redirect = sets_pc | flush_i;
  end

  // expected contents of the head entry
  always_comb begin
    xfer       = fetch_valid_o & fetch_ready_i;
    exp_instr  = word_at(fetch_pc_o);
    exp_cf     = fe_pkg::NO_CF;
    exp_target = fetch_pc_o + 32'd4;
    taken      = 1'b0;
    if (kind.exists(fetch_pc_o)) begin
      if (kind[fetch_pc_o] == 1) begin
        exp_cf     = fe_pkg::JUMP_CF;
        exp_target = fetch_pc_o + offs[fetch_pc_o];
      end else begin
        // known history wins over the backward taken hint
        taken = bht_v[fetch_pc_o[5:2]] ? bht_c[fetch_pc_o[5:2]][1]
                                       : offs[fetch_pc_o][31];
        if (taken) begin
          exp_cf     = fe_pkg::BRANCH_CF;
          exp_target = fetch_pc_o + offs[fetch_pc_o];
        end
      end
    end
  end

  // reference pc stream and predictor model
  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      exp_pc <= BOOT;
      for (int i = 0; i < 16; i++) begin
        bht_v[i] <= 1'b0;
        bht_c[i] <= 2'd0;
      end
    end else begin
      if (xfer) begin
        exp_pc <= exp_target;
        n_xfer <= n_xfer + 1;
      end
      if (set_pc_commit_i) begin
        exp_pc <= pc_commit_i + (halt_i ? 32'd0 : 32'd4);
      end else if (ex_valid_i) begin
        exp_pc <= trap_vector_i;
      end else if (eret_i) begin
        exp_pc <= epc_i;
      end else if (resolve_valid_i && resolve_mispredict_i) begin
        exp_pc <= resolve_target_i;
      end
      if (resolve_valid_i && resolve_is_branch_i) begin
        bht_v[resolve_pc_i[5:2]] <= 1'b1;
        if (!bht_v[resolve_pc_i[5:2]]) begin
          bht_c[resolve_pc_i[5:2]] <= resolve_taken_i ? 2'd2 : 2'd1;
        end else if (resolve_taken_i && bht_c[resolve_pc_i[5:2]] != 2'd3) begin
          bht_c[resolve_pc_i[5:2]] <= bht_c[resolve_pc_i[5:2]] + 2'd1;
        end else if (!resolve_taken_i && bht_c[resolve_pc_i[5:2]] != 2'd0) begin
          bht_c[resolve_pc_i[5:2]] <= bht_c[resolve_pc_i[5:2]] - 2'd1;
        end
      end
    end
  end

  // ------------------------------
  // checks on every transfer
  // ------------------------------
  assert property (@(posedge clk_i) disable iff (!rst_ni) xfer |-> fetch_pc_o == exp_pc)
    else begin
      errors = errors + 1;
      $display("[FAIL] fetch_pc_o exp %h got %h", $sampled(exp_pc), $sampled(fetch_pc_o));
    end
  assert property (@(posedge clk_i) disable iff (!rst_ni) xfer |-> fetch_instr_o == exp_instr)
    else begin
      errors = errors + 1;
      $display("[FAIL] fetch_instr_o exp %h got %h",
               $sampled(exp_instr), $sampled(fetch_instr_o));
    end
  assert property (@(posedge clk_i) disable iff (!rst_ni) xfer |-> fetch_cf_o == exp_cf)
    else begin
      errors = errors + 1;
      $display("[FAIL] fetch_cf_o exp %h got %h", $sampled(exp_cf), $sampled(fetch_cf_o));
    end
  assert property (@(posedge clk_i) disable iff (!rst_ni)
                   xfer |-> fetch_target_o == exp_target)
    else begin
      errors = errors + 1;
      $display("[FAIL] fetch_target_o exp %h got %h",
               $sampled(exp_target), $sampled(fetch_target_o));
    end

  // ------------------------------
  // memory side of a redirect
  // ------------------------------
  assert property (@(posedge clk_i) disable iff (!rst_ni) redirect |-> imem_kill_o)
    else begin
      errors = errors + 1;
      $display("[FAIL] imem_kill_o exp 1 got %h", $sampled(imem_kill_o));
    end
  // queue is empty right after the restart
  assert property (@(posedge clk_i) disable iff (!rst_ni) $past(sets_pc) |-> imem_req_o)
    else begin
      errors = errors + 1;
      $display("[FAIL] imem_req_o exp 1 got %h", $sampled(imem_req_o));
    end
  assert property (@(posedge clk_i) disable iff (!rst_ni)
                   $past(sets_pc) |-> imem_addr_o == exp_pc)
    else begin
      errors = errors + 1;
      $display("[FAIL] imem_addr_o exp %h got %h", $sampled(exp_pc), $sampled(imem_addr_o));
    end

  // run ends here if the stream stalls
  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles == LIMIT) begin
      $display("timeout, the run did not finish in %0d cycles", LIMIT);
      $display("TEST FAIL");
      $finish;
    end
  end

  task automatic wait_transfers(input int n);
    int stop;
    stop = n_xfer + n;
    while (n_xfer < stop) @(posedge clk_i);
  endtask

  // one cycle strobe then back to idle
  task automatic pulse(input logic cm, input logic hl, input logic ex, input logic er,
                       input logic rv, input logic br, input logic tk, input logic mp,
                       input logic [31:0] a, input logic [31:0] b);
    @(posedge clk_i);
    set_pc_commit_i <= cm;
    halt_i <= hl;
    pc_commit_i <= a;
    ex_valid_i <= ex;
    trap_vector_i <= b;
    eret_i <= er;
    epc_i <= a + 32'h800;
    resolve_valid_i <= rv;
    resolve_is_branch_i <= br;
    resolve_taken_i <= tk;
    resolve_mispredict_i <= mp;
    resolve_pc_i <= a;
    resolve_target_i <= b;
    @(posedge clk_i);
    {set_pc_commit_i, halt_i, ex_valid_i, eret_i} <= '0;
    {resolve_valid_i, resolve_is_branch_i, resolve_taken_i, resolve_mispredict_i} <= '0;
  endtask

  task automatic report(input int id, input string name);
    $display("test %0d %s: %0d errors", id, name, errors - err_mark);
    err_mark = errors;
  endtask

  initial begin
    rst_ni = 1'b0;
    boot_addr_i = BOOT;
    {flush_i, eret_i, ex_valid_i, set_pc_commit_i, halt_i} = '0;
    {epc_i, trap_vector_i, pc_commit_i} = '0;
    {resolve_valid_i, resolve_is_branch_i, resolve_taken_i, resolve_mispredict_i} = '0;
    {resolve_pc_i, resolve_target_i} = '0;
    {imem_ready_i, imem_valid_i, fetch_ready_i} = '0;
    imem_raddr_i = '0;
    imem_rdata_i = '0;
    err_mark = 0;
    place_jal(32'h2008, 32'h40);
    place_branch(32'h3010, -32'sd8);
    place_branch(32'h3100, 32'h20);
    place_branch(32'h4008, 32'h40);
    repeat (2) @(posedge clk_i);
    rst_ni <= 1'b1;

    wait_transfers(24);
    report(1, "sequential fetch");
    pulse(1, 1, 0, 0, 0, 0, 0, 0, 32'h2000, 0);
    wait_transfers(8);
    report(2, "jal prediction");
    pulse(1, 1, 0, 0, 0, 0, 0, 0, 32'h3000, 0);
    wait_transfers(10);
    pulse(1, 1, 0, 0, 0, 0, 0, 0, 32'h3100, 0);
    wait_transfers(6);
    report(3, "static branches");
    pulse(1, 1, 0, 0, 0, 0, 0, 0, 32'h4000, 0);
    wait_transfers(5);
    // each resolve also restarts the stream at the block start
    pulse(0, 0, 0, 0, 1, 1, 1, 1, 32'h4008, 32'h4000);
    wait_transfers(5);
    pulse(0, 0, 0, 0, 1, 1, 0, 1, 32'h4008, 32'h4000);
    wait_transfers(3);
    pulse(0, 0, 0, 0, 1, 1, 0, 1, 32'h4008, 32'h4000);
    wait_transfers(5);
    report(4, "bht training");
    pulse(0, 0, 1, 1, 0, 0, 0, 0, 32'h5000, 32'h5200);
    wait_transfers(6);
    pulse(0, 0, 0, 0, 1, 0, 0, 1, 32'h5000, 32'h5400);
    wait_transfers(6);
    report(5, "redirect precedence");
    pulse(1, 1, 0, 0, 0, 0, 0, 0, 32'h6000, 0);
    wait_transfers(4);
    pulse(1, 0, 0, 0, 0, 0, 0, 0, 32'h6100, 0);
    wait_transfers(4);
    pulse(1, 1, 1, 0, 0, 0, 0, 0, 32'h6200, 32'h5000);
    wait_transfers(4);
    report(6, "commit pc");

    $display("done: %0d transfers checked, %0d errors", n_xfer, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

/* tb.f */
+incdir+design
design/fe_pkg.sv
design/instr_scan.sv
design/bht.sv
design/fetch_predict.sv
design/pc_gen.sv
design/fetch_queue.sv
design/frontend_top.sv
tb/tb_frontend.sv

/* Makefile */
SIM  := obj_dir/Vtb_frontend
SRCS := $(filter-out +%,$(shell cat tb.f)) design/fe_cfg.svh

.PHONY: all run clean

all: $(SIM)

$(SIM): tb.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module tb_frontend -o Vtb_frontend

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx 'TEST PASS'

clean:
	rm -rf obj_dir
